// ==== design/mipsPkg.sv ====
package mipsPkg;

  // ====================
  // vector types
  // ====================

  // data memory depth in words
  localparam int memWords = 128;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regAddr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [$clog2(memWords)-1:0] memAddr_t;
  typedef logic [3:0]  aluCtrl_t;
  typedef logic [1:0]  aluOp_t;

  // ====================
  // instruction encodings
  // ====================

  // primary opcodes
  localparam opcode_t opR   = 6'b000000;
  localparam opcode_t opLw  = 6'b100011;
  localparam opcode_t opSw  = 6'b101011;
  localparam opcode_t opBeq = 6'b000100;
  localparam opcode_t opJ   = 6'b000010;
  localparam opcode_t opJal = 6'b000011;

  // r-type function field
  localparam funct_t fnAdd = 6'b100000;
  localparam funct_t fnSub = 6'b100010;
  localparam funct_t fnAnd = 6'b100100;
  localparam funct_t fnOr  = 6'b100101;
  localparam funct_t fnSlt = 6'b101010;

  // alu operation select
  localparam aluCtrl_t aluAnd = 4'b0000;
  localparam aluCtrl_t aluOr  = 4'b0001;
  localparam aluCtrl_t aluAdd = 4'b0010;
  localparam aluCtrl_t aluSub = 4'b0110;
  localparam aluCtrl_t aluSlt = 4'b0111;

  // operation class from decoder to alu
  localparam aluOp_t aluClsMem    = 2'b00;
  localparam aluOp_t aluClsBranch = 2'b01;
  localparam aluOp_t aluClsR      = 2'b10;

  // jal return address lands here
  localparam regAddr_t linkReg = 5'd31;

endpackage

// ==== design/pcUnit.sv ====
`timescale 1ns/1ns

module pcUnit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  branch,
  input  logic                  jump,
  input  logic                  zero,
  input  mipsPkg::word_t        offset,
  input  logic           [25:0] target,
  output mipsPkg::word_t        pc,
  output mipsPkg::word_t        pcPlus8
);

  mipsPkg::word_t pcPlus4;
  mipsPkg::word_t branchTarget;
  mipsPkg::word_t jumpTarget;
  mipsPkg::word_t pcNext;

  // sequential and link addresses
  assign pcPlus4 = pc + 32'd4;
  assign pcPlus8 = pc + 32'd8;

  // offset counts words, relative to the delay-free pc+4
  assign branchTarget = pcPlus4 + {offset[29:0], 2'b00};

  // pseudo-direct, keeps the 256MB region of pc+4
  assign jumpTarget = {pcPlus4[31:28], target, 2'b00};

  // jump wins over a taken branch
  always_comb begin
    if (jump) begin
      pcNext = jumpTarget;
    end else if (branch && zero) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // pc register, fetch restarts at address 0
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

// ==== design/controlDecoder.sv ====
`timescale 1ns/1ns

module controlDecoder (
  input  mipsPkg::opcode_t opcode,
  output logic             regDst,
  output logic             aluSrc,
  output logic             memToReg,
  output logic             regWrite,
  output logic             memRead,
  output logic             memWrite,
  output logic             branch,
  output logic             jump,
  output logic             link,
  output mipsPkg::aluOp_t  aluOp
);

  // ====================
  // main decode
  // ====================

  always_comb begin
    // safe defaults, nothing written and no memory access
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    aluOp    = mipsPkg::aluClsMem;

    case (opcode)
      // add, sub, and, or, slt
      mipsPkg::opR: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        aluOp    = mipsPkg::aluClsR;
      end
      // base plus offset, data back from memory
      mipsPkg::opLw: begin
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
      end
      // store rt at base plus offset
      mipsPkg::opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      // equality via subtract and zero flag
      mipsPkg::opBeq: begin
        branch = 1'b1;
        aluOp  = mipsPkg::aluClsBranch;
      end
      mipsPkg::opJ: begin
        jump = 1'b1;
      end
      // jump and write pc+8 to $ra
      mipsPkg::opJal: begin
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      // unsupported opcode behaves as a no-op
      default: ;
    endcase
  end

endmodule

// ==== design/aluUnit.sv ====
`timescale 1ns/1ns

module aluUnit (
  input  mipsPkg::word_t  a,
  input  mipsPkg::word_t  b,
  input  mipsPkg::aluOp_t aluOp,
  input  mipsPkg::funct_t funct,
  output mipsPkg::word_t  result,
  output logic            zero
);

  mipsPkg::aluCtrl_t aluCtrl;

  // ====================
  // operation select
  // ====================

  always_comb begin
    case (aluOp)
      // address calculation
      mipsPkg::aluClsMem:    aluCtrl = mipsPkg::aluAdd;
      // beq compares by subtraction
      mipsPkg::aluClsBranch: aluCtrl = mipsPkg::aluSub;
      mipsPkg::aluClsR: begin
        case (funct)
          mipsPkg::fnAdd: aluCtrl = mipsPkg::aluAdd;
          mipsPkg::fnSub: aluCtrl = mipsPkg::aluSub;
          mipsPkg::fnAnd: aluCtrl = mipsPkg::aluAnd;
          mipsPkg::fnOr:  aluCtrl = mipsPkg::aluOr;
          mipsPkg::fnSlt: aluCtrl = mipsPkg::aluSlt;
          // unknown funct, falls to zero result below
          default:        aluCtrl = '1;
        endcase
      end
      default: aluCtrl = '1;
    endcase
  end

  // ====================
  // datapath
  // ====================

  always_comb begin
    case (aluCtrl)
      mipsPkg::aluAdd: result = a + b;
      mipsPkg::aluSub: result = a - b;
      mipsPkg::aluAnd: result = a & b;
      mipsPkg::aluOr:  result = a | b;
      // two's complement compare
      mipsPkg::aluSlt: result = {31'd0, $signed(a) < $signed(b)};
      default:         result = '0;
    endcase
  end

  // used by beq only
  assign zero = (result == '0);

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ns

module regFile (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  mipsPkg::regAddr_t rAddr1,
  input  mipsPkg::regAddr_t rAddr2,
  input  mipsPkg::regAddr_t wAddr,
  input  mipsPkg::word_t    wData,
  output mipsPkg::word_t    rData1,
  output mipsPkg::word_t    rData2
);

  // 32 general purpose registers
  mipsPkg::word_t regs [32];

  // write port, $zero never takes a value
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wAddr != 5'd0)) begin
      regs[wAddr] <= wData;
    end
  end

  // ====================
  // read ports
  // ====================

  // combinational, same-cycle read of old value
  always_comb begin
    if (rAddr1 == 5'd0) begin
      rData1 = '0;
    end else begin
      rData1 = regs[rAddr1];
    end
  end

  always_comb begin
    if (rAddr2 == 5'd0) begin
      rData2 = '0;
    end else begin
      rData2 = regs[rAddr2];
    end
  end

endmodule

// ==== design/mipsCore.sv ====
`timescale 1ns/1ns

module mipsCore (
  input  logic              clk,
  input  logic              rst,
  // instruction memory
  output mipsPkg::word_t    instrAddr,
  input  mipsPkg::word_t    instr,
  // data memory, sram style with active low strobes
  output logic              dataCen,
  output logic              dataWen,
  output mipsPkg::memAddr_t dataAddr,
  output mipsPkg::word_t    dataWdata,
  input  mipsPkg::word_t    dataRdata,
  // write-back observation
  output mipsPkg::word_t    rfWriteData
);

  // ====================
  // instruction fields
  // ====================

  mipsPkg::opcode_t  opcode;
  mipsPkg::funct_t   funct;
  mipsPkg::regAddr_t rs;
  mipsPkg::regAddr_t rt;
  mipsPkg::regAddr_t rd;
  logic [15:0]       imm;
  logic [25:0]       target;
  mipsPkg::word_t    immExt;

  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign imm    = instr[15:0];
  assign funct  = instr[5:0];
  assign target = instr[25:0];

  // sign extend for address offset and branch displacement
  assign immExt = {{16{imm[15]}}, imm};

  // control
  logic            regDst;
  logic            aluSrc;
  logic            memToReg;
  logic            regWrite;
  logic            memRead;
  logic            memWrite;
  logic            branch;
  logic            jump;
  logic            link;
  mipsPkg::aluOp_t aluOp;

  // datapath
  mipsPkg::word_t    pc;
  mipsPkg::word_t    pcPlus8;
  mipsPkg::word_t    rData1;
  mipsPkg::word_t    rData2;
  mipsPkg::word_t    aluB;
  mipsPkg::word_t    aluResult;
  logic              aluZero;
  mipsPkg::regAddr_t wAddr;

  pcUnit uPc (
    .clk     (clk),
    .rst     (rst),
    .branch  (branch),
    .jump    (jump),
    .zero    (aluZero),
    .offset  (immExt),
    .target  (target),
    .pc      (pc),
    .pcPlus8 (pcPlus8)
  );

  controlDecoder uCtrl (
    .opcode   (opcode),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .memRead  (memRead),
    .memWrite (memWrite),
    .branch   (branch),
    .jump     (jump),
    .link     (link),
    .aluOp    (aluOp)
  );

  regFile uRf (
    .clk    (clk),
    .rst    (rst),
    .we     (regWrite),
    .rAddr1 (rs),
    .rAddr2 (rt),
    .wAddr  (wAddr),
    .wData  (rfWriteData),
    .rData1 (rData1),
    .rData2 (rData2)
  );

  aluUnit uAlu (
    .a      (rData1),
    .b      (aluB),
    .aluOp  (aluOp),
    .funct  (funct),
    .result (aluResult),
    .zero   (aluZero)
  );

  // ====================
  // muxes
  // ====================

  // second operand, immediate for lw/sw
  assign aluB = aluSrc ? immExt : rData2;

  // destination, rd for r-type, rt for lw, $ra for jal
  assign wAddr = link ? mipsPkg::linkReg : (regDst ? rd : rt);

  // write-back source
  assign rfWriteData = link ? pcPlus8 : (memToReg ? dataRdata : aluResult);

  // memory ports, word address from byte address
  assign instrAddr = pc;
  assign dataCen   = ~(memRead | memWrite);
  assign dataWen   = ~memWrite;
  assign dataAddr  = aluResult[8:2];
  assign dataWdata = rData2;

endmodule

// ==== tests/mipsCoreTb.sv ====
`timescale 1ns/1ns

module mipsCoreTb;

  logic              clk;
  logic              rst;
  mipsPkg::word_t    instrAddr;
  mipsPkg::word_t    instr;
  logic              dataCen;
  logic              dataWen;
  mipsPkg::memAddr_t dataAddr;
  mipsPkg::word_t    dataWdata;
  mipsPkg::word_t    dataRdata;
  mipsPkg::word_t    rfWriteData;

  mipsPkg::word_t imem [256];
  mipsPkg::word_t dmem [mipsPkg::memWords];
  int assertErrors = 0;
  int finalErrors = 0;

  // reference model state, one instruction per clock
  mipsPkg::word_t    refPc;
  mipsPkg::word_t    refRegs [32];
  mipsPkg::word_t    refMem [mipsPkg::memWords];
  logic              expWe;
  mipsPkg::regAddr_t expDest;
  mipsPkg::word_t    expWData;
  logic              expCen;
  logic              expWen;
  mipsPkg::memAddr_t expAddr;
  mipsPkg::word_t    expStore;
  mipsPkg::word_t    expNext;

  mipsCore DUT (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .dataCen(dataCen), .dataWen(dataWen), .dataAddr(dataAddr),
    .dataWdata(dataWdata), .dataRdata(dataRdata), .rfWriteData(rfWriteData)
  );

  always #20 clk = ~clk;

  function automatic mipsPkg::word_t xorshift(input mipsPkg::word_t x);
    mipsPkg::word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // n-th word of the xorshift stream, never zero
  function automatic mipsPkg::word_t fillWord(input int idx);
    mipsPkg::word_t x;
    x = 32'hd549a35e;
    for (int k = 0; k <= idx; k++) begin
      x = xorshift(x);
    end
    return x;
  endfunction

  task automatic reportMismatch(input string name, input mipsPkg::word_t expVal,
                                input mipsPkg::word_t actVal);
    $display("** Error [%s] expected %h, actual %h at %0t", name, expVal, actVal, $time);
    assertErrors++;
  endtask

  // ====================
  // memory models
  // ====================

  assign instr     = imem[instrAddr[9:2]];
  assign dataRdata = (!dataCen && dataWen) ? dmem[dataAddr] : '0;

  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < mipsPkg::memWords; i++) dmem[i] <= fillWord(i);
    end else if (!dataCen && !dataWen) begin
      dmem[dataAddr] <= dataWdata;
    end
  end

  // ====================
  // reference model
  // ====================

  always_comb begin
    mipsPkg::word_t ins;
    mipsPkg::word_t opA;
    mipsPkg::word_t opB;
    mipsPkg::word_t sext;
    mipsPkg::word_t pc4;
    mipsPkg::word_t ea;
    ins  = imem[refPc[9:2]];
    opA  = refRegs[ins[25:21]];
    opB  = refRegs[ins[20:16]];
    sext = {{16{ins[15]}}, ins[15:0]};
    pc4  = refPc + 32'd4;
    ea   = opA + sext;
    // no write, no access, fall through
    expWe    = 1'b0;
    expDest  = ins[20:16];
    expWData = '0;
    expCen   = 1'b1;
    expWen   = 1'b1;
    expAddr  = ea[8:2];
    expStore = opB;
    expNext  = pc4;
    case (ins[31:26])
      mipsPkg::opR: begin
        expWe   = 1'b1;
        expDest = ins[15:11];
        case (ins[5:0])
          mipsPkg::fnAdd: expWData = opA + opB;
          mipsPkg::fnSub: expWData = opA - opB;
          mipsPkg::fnAnd: expWData = opA & opB;
          mipsPkg::fnOr:  expWData = opA | opB;
          mipsPkg::fnSlt: expWData = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
          default:        expWData = '0;
        endcase
      end
      mipsPkg::opLw: begin
        expWe    = 1'b1;
        expWData = refMem[ea[8:2]];
        expCen   = 1'b0;
      end
      mipsPkg::opSw: begin
        expCen = 1'b0;
        expWen = 1'b0;
      end
      mipsPkg::opBeq: if (opA == opB) expNext = pc4 + {sext[29:0], 2'b00};
      mipsPkg::opJ:   expNext = {pc4[31:28], ins[25:0], 2'b00};
      mipsPkg::opJal: begin
        expNext  = {pc4[31:28], ins[25:0], 2'b00};
        expWe    = 1'b1;
        expDest  = mipsPkg::linkReg;
        expWData = refPc + 32'd8;
      end
      default: ;
    endcase
  end

  // commit, $zero never written
  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      refPc <= '0;
      for (int i = 0; i < 32; i++) refRegs[i] <= '0;
      for (int i = 0; i < mipsPkg::memWords; i++) refMem[i] <= fillWord(i);
    end else begin
      if (expWe && expDest != 5'd0) refRegs[expDest] <= expWData;
      if (!expCen && !expWen) refMem[expAddr] <= expStore;
      refPc <= expNext;
    end
  end

  // ====================
  // checks at mid cycle
  // ====================

  resetFetch: assert property (@(negedge clk) rst || instrAddr === '0)
    else reportMismatch("resetFetch", '0, instrAddr);
  pcTrack: assert property (@(negedge clk) disable iff (!rst) instrAddr === refPc)
    else reportMismatch("pcTrack", refPc, instrAddr);
  writeBack: assert property (@(negedge clk) disable iff (!rst)
    !expWe || rfWriteData === expWData)
    else reportMismatch("writeBack", expWData, rfWriteData);
  chipEnable: assert property (@(negedge clk) disable iff (!rst) dataCen === expCen)
    else reportMismatch("chipEnable", {31'd0, expCen}, {31'd0, dataCen});
  writeEnable: assert property (@(negedge clk) disable iff (!rst) dataWen === expWen)
    else reportMismatch("writeEnable", {31'd0, expWen}, {31'd0, dataWen});
  memAddr: assert property (@(negedge clk) disable iff (!rst) expCen || dataAddr === expAddr)
    else reportMismatch("memAddr", {25'd0, expAddr}, {25'd0, dataAddr});
  storeData: assert property (@(negedge clk) disable iff (!rst)
    expWen || dataWdata === expStore)
    else reportMismatch("storeData", expStore, dataWdata);

  initial begin
    mipsPkg::word_t lastAddr;
    int cycles;
    logic settled;
    clk = 1'b0;
    rst = 1'b0;
    // unused rom words decode as an unknown opcode
    for (int i = 0; i < 256; i++) imem[i] = {6'b111111, 18'd0, i[7:0]};
    $readmemh("tests/program.hex", imem);
    repeat (8) @(posedge clk);
    #1 rst = 1'b1;
    // self-jump shows up as a repeated fetch address
    @(negedge clk);
    lastAddr = instrAddr;
    cycles   = 0;
    settled  = 1'b0;
    while (!settled && cycles < 400) begin
      @(negedge clk);
      settled  = (instrAddr == lastAddr);
      lastAddr = instrAddr;
      cycles++;
    end
    @(posedge clk);
    if (!settled) begin
      $display("timeout: the program never reached its closing self-jump");
      finalErrors++;
    end else begin
      checksum: assert (dmem[3] === refRegs[13]) else begin
        $display("** Error [checksum] expected %h, actual %h", refRegs[13], dmem[3]);
        finalErrors++;
      end
    end
    $display("assertion errors: %0d, final check errors: %0d", assertErrors, finalErrors);
    if (assertErrors == 0 && finalErrors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== tests/program.hex ====
// one 32-bit instruction word per line in hex, from word address 0 upward
// words past the end keep the testbench fill pattern
00003025 // 00 or   $6, $0, $0
8C010000 // 04 lw   $1, 0($0)
8C020004 // 08 lw   $2, 4($0)
00011822 // 0c sub  $3, $0, $1
0061202A // 10 slt  $4, $3, $1
0023282A // 14 slt  $5, $1, $3
00223824 // 18 and  $7, $1, $2
00224025 // 1c or   $8, $1, $2
00220020 // 20 add  $0, $1, $2
00014820 // 24 add  $9, $0, $1
10200005 // 28 beq  $1, $0, not taken since memory words are nonzero
10290001 // 2c beq  $1, $9, taken to 34
00215020 // 30 skipped
FC220820 // 34 unknown opcode
0C000010 // 38 jal  40
00215020 // 3c skipped
AC020008 // 40 sw   $2, 8($0)
8C0C0008 // 44 lw   $12, 8($0)
08000014 // 48 j    50
00215020 // 4c skipped
00226820 // 50 add  $13, $1, $2
01A36820 // 54 add  $13, $13, $3
01A46820 // 58 add  $13, $13, $4
01A56820 // 5c add  $13, $13, $5
01A76820 // 60 add  $13, $13, $7
01A86820 // 64 add  $13, $13, $8
01AC6820 // 68 add  $13, $13, $12
01BF6820 // 6c add  $13, $13, $31
AC0D000C // 70 sw   $13, 12($0)
0800001D // 74 j    74

// ==== flist.f ====
design/mipsPkg.sv
design/pcUnit.sv
design/controlDecoder.sv
design/aluUnit.sv
design/regFile.sv
design/mipsCore.sv
tests/mipsCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the mipsCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns \
  --top-module mipsCoreTb -f flist.f -o mipsCoreSim

./obj_dir/mipsCoreSim | tee sim.log

grep -q "Verification passed" sim.log
